//--- hdl/gpio_cfg_pkg.sv
// build-time configuration of the gpio block
// only the 2:1 gear ratio is exercised, and slot_t is sized from GEAR_RATIO
`default_nettype none

package gpio_cfg_pkg;

	// number of bidirectional pins
	localparam int PIN_COUNT = 4;

	// full-rate cycles that make up one half-rate word
	localparam int GEAR_RATIO = 2;

	// width of one flattened half-rate word, all lanes of all pins
	localparam int WORD_BITS = PIN_COUNT * GEAR_RATIO;

	// lane index within the current half-rate word
	typedef logic [$clog2(GEAR_RATIO)-1:0] slot_t;

endpackage : gpio_cfg_pkg

`default_nettype wire

//--- hdl/gpio_lane_pkg.sv
// lane and word types shared by the gearbox modules
// the flattened bit order of hr_word_t is slot-major, lane 0 in the low bits
`default_nettype none

package gpio_lane_pkg;

	import gpio_cfg_pkg::*;

	// one bit per pin, as seen on the pad side in one full-rate cycle
	typedef logic [PIN_COUNT-1:0] pin_vec_t;

	// a half-rate word is GEAR_RATIO pin vectors, indexed by lane
	// bit lane*PIN_COUNT+pin of the flat word belongs to that pin and lane,
	// which the packed layout gives for free
	typedef pin_vec_t [GEAR_RATIO-1:0] hr_word_t;

endpackage : gpio_lane_pkg

`default_nettype wire

//--- hdl/gear_phase_ctr.sv
// slot counter that paces the half-rate gearbox on fr_out_clk
// advances only on edges with cke high; sclr has no effect on it
`timescale 1ns/10ps
`default_nettype none

module gear_phase_ctr
	import gpio_cfg_pkg::*;
(
	input  logic  fr_out_clk,
	input  logic  rst_n,
	input  logic  cke,
	output slot_t slot
);

	// last lane of a word, after which the count wraps to lane 0
	localparam slot_t LAST_SLOT = slot_t'(GEAR_RATIO - 1);

	slot_t slot_q;

	// output and input gearing both follow this one phase reference,
	// so a word leaving on the pins and a word arriving stay aligned
	always_ff @(posedge fr_out_clk) begin
		if (!rst_n) begin
			slot_q <= '0;
		end else if (cke) begin
			if (slot_q == LAST_SLOT) begin
				slot_q <= '0;
			end else begin
				slot_q <= slot_q + slot_t'(1);
			end
		end
	end

	assign slot = slot_q;

endmodule : gear_phase_ctr

`default_nettype wire

//--- hdl/gear_serializer.sv
// half-rate to full-rate serializer for one word of per-pin lanes
// lane_word_t must hold GEAR_RATIO lanes of PIN_COUNT bits, lane 0 lowest
// the word is sampled at slot 0 only, there is no back-pressure
`timescale 1ns/10ps
`default_nettype none

module gear_serializer
	import gpio_cfg_pkg::*, gpio_lane_pkg::*;
#(
	parameter type lane_word_t = hr_word_t
) (
	input  logic       fr_out_clk,
	input  logic       rst_n,
	input  logic       cke,
	input  logic       sclr,
	input  slot_t      slot,
	input  lane_word_t word,
	output pin_vec_t   pins
);

	// number of lanes carried by the payload type
	localparam int LANES = $bits(lane_word_t) / PIN_COUNT;

	// lane view of the incoming word, independent of how the type is declared
	logic [LANES-1:0][PIN_COUNT-1:0] word_lanes;

	// lanes 1 and up wait here while the earlier lanes are on the pins
	pin_vec_t [LANES-1:1] hold_q;

	// registered per-pin output, one lane per enabled cycle
	pin_vec_t pins_q;

	assign word_lanes = word;

	// at slot 0 lane 0 goes straight to the pins and the rest is parked,
	// so the next word can be taken while the last lane is still driven
	always_ff @(posedge fr_out_clk) begin
		if (!rst_n || sclr) begin
			pins_q <= '0;
			hold_q <= '0;
		end else if (cke) begin
			if (slot == '0) begin
				pins_q <= word_lanes[0];
				hold_q <= word_lanes[LANES-1:1];
			end else begin
				for (int k = 1; k < LANES; k++) begin
					if (slot == slot_t'(k)) begin
						pins_q <= hold_q[k];
					end
				end
			end
		end
	end

	// lane k is visible for the cycle after the edge at which slot was k
	assign pins = pins_q;

endmodule : gear_serializer

`default_nettype wire

//--- hdl/gear_deserializer.sv
// full-rate to half-rate deserializer for the pad input samples
// dout_valid pulses for one cycle per word and must be consumed at once
`timescale 1ns/10ps
`default_nettype none

module gear_deserializer
	import gpio_cfg_pkg::*, gpio_lane_pkg::*;
(
	input  logic     fr_out_clk,
	input  logic     rst_n,
	input  logic     cke,
	input  logic     sclr,
	input  slot_t    slot,
	input  pin_vec_t pad_in,
	output hr_word_t dout,
	output logic     dout_valid
);

	// slot at which the word is complete
	localparam slot_t LAST_SLOT = slot_t'(GEAR_RATIO - 1);

	// samples of every lane but the last, which is taken directly from pad_in
	pin_vec_t [GEAR_RATIO-2:0] lane_q;

	hr_word_t dout_q;
	logic     valid_q;

	// capture the pad into the lane that matches the current slot
	always_ff @(posedge fr_out_clk) begin
		if (!rst_n || sclr) begin
			lane_q <= '0;
		end else if (cke) begin
			for (int k = 0; k < GEAR_RATIO - 1; k++) begin
				if (slot == slot_t'(k)) begin
					lane_q[k] <= pad_in;
				end
			end
		end
	end

	// publish the assembled word at the last slot
	// valid drops on the next edge even when cke is low, so it never stretches
	always_ff @(posedge fr_out_clk) begin
		if (!rst_n || sclr) begin
			dout_q  <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (cke && slot == LAST_SLOT) begin
				dout_q  <= {pad_in, lane_q};
				valid_q <= 1'b1;
			end
		end
	end

	assign dout       = dout_q;
	assign dout_valid = valid_q;

endmodule : gear_deserializer

`default_nettype wire

//--- hdl/gpio_top.sv
// bidirectional gpio block with a 2:1 half-rate gearbox, single clock
// the tri-state pad itself lives outside, driven from pad_out and pad_oe
// din and oe are sampled while hr_strobe and cke are both high
`timescale 1ns/10ps
`default_nettype none

module gpio_top
	import gpio_cfg_pkg::*, gpio_lane_pkg::*;
(
	input  logic     fr_out_clk,
	input  logic     rst_n,
	input  logic     cke,
	input  logic     sclr,
	input  hr_word_t din,
	input  hr_word_t oe,
	input  pin_vec_t pad_in,
	output pin_vec_t pad_out,
	output pin_vec_t pad_oe,
	output hr_word_t dout,
	output logic     dout_valid,
	output logic     hr_strobe
);

	slot_t slot;

	// shared phase for both output serializers and the input capture
	gear_phase_ctr phase_ctr (
		.fr_out_clk (fr_out_clk),
		.rst_n      (rst_n),
		.cke        (cke),
		.slot       (slot)
	);

	// hr_strobe marks the cycle in which a new half-rate word is taken
	assign hr_strobe = (slot == '0);

	// output data path
	gear_serializer #(
		.lane_word_t (hr_word_t)
	) data_ser (
		.fr_out_clk (fr_out_clk),
		.rst_n      (rst_n),
		.cke        (cke),
		.sclr       (sclr),
		.slot       (slot),
		.word       (din),
		.pins       (pad_out)
	);

	// output enable path, same lane order as the data
	gear_serializer #(
		.lane_word_t (hr_word_t)
	) oe_ser (
		.fr_out_clk (fr_out_clk),
		.rst_n      (rst_n),
		.cke        (cke),
		.sclr       (sclr),
		.slot       (slot),
		.word       (oe),
		.pins       (pad_oe)
	);

	// input capture, two samples per pin packed into one word
	gear_deserializer deser (
		.fr_out_clk (fr_out_clk),
		.rst_n      (rst_n),
		.cke        (cke),
		.sclr       (sclr),
		.slot       (slot),
		.pad_in     (pad_in),
		.dout       (dout),
		.dout_valid (dout_valid)
	);

endmodule : gpio_top

`default_nettype wire

//--- bench/gpio_props.sv
// concurrent checks on the gpio_top outputs, bound into every gpio_top instance
// all properties are off while rst_n is low
`timescale 1ns/10ps
`default_nettype none

module gpio_props
	import gpio_lane_pkg::*;
(
	input logic     fr_out_clk,
	input logic     rst_n,
	input logic     cke,
	input logic     sclr,
	input pin_vec_t pad_out,
	input pin_vec_t pad_oe,
	input hr_word_t dout,
	input logic     dout_valid,
	input logic     hr_strobe
);

	// one pulse per assembled word, never stretched
	valid_single : assert property (@(posedge fr_out_clk) disable iff (!rst_n)
		dout_valid |=> !dout_valid)
		else $error("dout_valid stayed high for two cycles in a row");

	// a disabled edge must leave every registered output alone
	frozen_hold : assert property (@(posedge fr_out_clk) disable iff (!rst_n)
		(rst_n && !cke && !sclr) |=> ($stable(pad_out) && $stable(pad_oe) && $stable(dout)))
		else $error("outputs changed across an edge with cke low");

	// with a 2:1 gear ratio the strobe flips on every enabled edge
	strobe_toggle : assert property (@(posedge fr_out_clk) disable iff (!rst_n)
		(rst_n && cke) |=> (hr_strobe != $past(hr_strobe)))
		else $error("hr_strobe did not alternate on an enabled edge");

endmodule : gpio_props

bind gpio_top gpio_props props_i (
	.fr_out_clk (fr_out_clk),
	.rst_n      (rst_n),
	.cke        (cke),
	.sclr       (sclr),
	.pad_out    (pad_out),
	.pad_oe     (pad_oe),
	.dout       (dout),
	.dout_valid (dout_valid),
	.hr_strobe  (hr_strobe)
);

`default_nettype wire

//--- bench/gpio_tb.sv
// directed testbench for gpio_top, written for the 2:1 gear ratio only
// the tri-state pad is modelled here, an external value shows where pad_oe is low
`timescale 1ns/10ps
`default_nettype none

module gpio_tb
	import gpio_cfg_pkg::*, gpio_lane_pkg::*;
();

	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_WORDS = 12;
	localparam int CKE_PAUSE = 5;
	localparam logic [31:0] SEED = 32'hf74c;
	// rough length of all tests together in cycles, the watchdog allows twice that
	localparam int TEST_CYCLES = RESET_CYCLES + 4 * (NUM_WORDS + 3) * GEAR_RATIO
		+ CKE_PAUSE + 16;
	localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

	logic                 fr_out_clk;
	logic                 rst_n;
	logic                 cke;
	logic                 sclr;
	logic [WORD_BITS-1:0] din;
	logic [WORD_BITS-1:0] oe;
	pin_vec_t             ext_in;
	pin_vec_t             pad_in;
	pin_vec_t             pad_out;
	pin_vec_t             pad_oe;
	logic [WORD_BITS-1:0] dout;
	logic                 dout_valid;
	logic                 hr_strobe;

	gpio_top gpio_top_i (
		.fr_out_clk (fr_out_clk),
		.rst_n      (rst_n),
		.cke        (cke),
		.sclr       (sclr),
		.din        (din),
		.oe         (oe),
		.pad_in     (pad_in),
		.pad_out    (pad_out),
		.pad_oe     (pad_oe),
		.dout       (dout),
		.dout_valid (dout_valid),
		.hr_strobe  (hr_strobe)
	);

	// board-level pad: the DUT drives where enabled, the outside world elsewhere
	assign pad_in = (pad_out & pad_oe) | (ext_in & ~pad_oe);

	always #HALF_PERIOD fr_out_clk = ~fr_out_clk;

	// pins of lane k, where flat bit k*PIN_COUNT+pin belongs to that pin and lane
	function automatic pin_vec_t lane_of(input logic [WORD_BITS-1:0] w, input int k);
		pin_vec_t r;
		for (int p = 0; p < PIN_COUNT; p++) begin
			r[p] = w[k * PIN_COUNT + p];
		end
		return r;
	endfunction

	function automatic logic [WORD_BITS-1:0] pack_lanes(input pin_vec_t l0, input pin_vec_t l1);
		logic [WORD_BITS-1:0] w;
		for (int p = 0; p < PIN_COUNT; p++) begin
			w[p] = l0[p];
			w[PIN_COUNT + p] = l1[p];
		end
		return w;
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
				$time, what, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1, "value mismatch");
		end
	endtask

	// returns at the rising edge where slot is 1, so inputs driven now meet slot 0
	task automatic wait_word_end_edge;
		@(negedge fr_out_clk);
		while (hr_strobe) begin
			@(negedge fr_out_clk);
		end
		@(posedge fr_out_clk);
	endtask

	task automatic reset_dut;
		repeat (RESET_CYCLES) @(posedge fr_out_clk);
		rst_n <= 1'b1;
	endtask

	task automatic verify_reset_state;
		@(negedge fr_out_clk);
		check_eq(32'(pad_oe), 32'(0), "pad_oe after reset");
		check_eq(32'(pad_out), 32'(0), "pad_out after reset");
		check_eq(32'(dout), 32'(0), "dout after reset");
		check_eq(32'(dout_valid), 32'(0), "dout_valid after reset");
		check_eq(32'(hr_strobe), 32'(1), "hr_strobe after reset");
	endtask

	task automatic output_gearing;
		logic [WORD_BITS-1:0] w [NUM_WORDS];
		logic [WORD_BITS-1:0] e [NUM_WORDS];
		for (int j = 0; j < NUM_WORDS; j++) begin
			w[j] = WORD_BITS'($urandom);
			e[j] = WORD_BITS'($urandom);
		end
		wait_word_end_edge();
		for (int j = 0; j <= NUM_WORDS; j++) begin
			if (j < NUM_WORDS) begin
				din <= w[j];
				oe <= e[j];
			end
			@(negedge fr_out_clk);
			if (j > 0) begin
				check_eq(32'(pad_out), 32'(lane_of(w[j-1], 1)), "pad_out lane 1");
				check_eq(32'(pad_oe), 32'(lane_of(e[j-1], 1)), "pad_oe lane 1");
			end
			if (j < NUM_WORDS) begin
				@(posedge fr_out_clk);
				@(negedge fr_out_clk);
				check_eq(32'(pad_out), 32'(lane_of(w[j], 0)), "pad_out lane 0");
				check_eq(32'(pad_oe), 32'(lane_of(e[j], 0)), "pad_oe lane 0");
				@(posedge fr_out_clk);
			end
		end
	endtask

	task automatic input_gearing;
		pin_vec_t a [NUM_WORDS];
		pin_vec_t b [NUM_WORDS];
		for (int j = 0; j < NUM_WORDS; j++) begin
			a[j] = PIN_COUNT'($urandom);
			b[j] = PIN_COUNT'($urandom);
		end
		// drain the enable pipeline so every pin listens to the outside
		wait_word_end_edge();
		oe <= '0;
		din <= '0;
		repeat (GEAR_RATIO) @(posedge fr_out_clk);
		for (int j = 0; j <= NUM_WORDS; j++) begin
			if (j < NUM_WORDS) begin
				ext_in <= a[j];
			end
			@(negedge fr_out_clk);
			if (j > 0) begin
				check_eq(32'(dout_valid), 32'(1), "dout_valid at word end");
				check_eq(32'(dout), 32'(pack_lanes(a[j-1], b[j-1])), "dout from pad samples");
			end
			if (j < NUM_WORDS) begin
				@(posedge fr_out_clk);
				ext_in <= b[j];
				@(negedge fr_out_clk);
				check_eq(32'(dout_valid), 32'(0), "dout_valid one cycle only");
				@(posedge fr_out_clk);
			end
		end
	endtask

	task automatic cke_hold;
		logic [WORD_BITS-1:0] w;
		logic [WORD_BITS-1:0] e;
		logic [WORD_BITS-1:0] dout_held;
		pin_vec_t             out_held;
		pin_vec_t             oe_held;
		logic                 strobe_held;
		w = WORD_BITS'($urandom);
		e = WORD_BITS'($urandom);
		wait_word_end_edge();
		din <= w;
		oe <= e;
		@(posedge fr_out_clk);
		// pause with lane 1 still waiting in the hold register
		cke <= 1'b0;
		@(negedge fr_out_clk);
		check_eq(32'(pad_out), 32'(lane_of(w, 0)), "pad_out lane 0 before pause");
		out_held = pad_out;
		oe_held = pad_oe;
		dout_held = dout;
		strobe_held = hr_strobe;
		for (int i = 0; i < CKE_PAUSE; i++) begin
			@(posedge fr_out_clk);
			din <= WORD_BITS'($urandom);
			ext_in <= PIN_COUNT'($urandom);
			if (i == CKE_PAUSE - 1) begin
				cke <= 1'b1;
			end
			@(negedge fr_out_clk);
			check_eq(32'(hr_strobe), 32'(strobe_held), "hr_strobe during pause");
			check_eq(32'(pad_out), 32'(out_held), "pad_out during pause");
			check_eq(32'(pad_oe), 32'(oe_held), "pad_oe during pause");
			check_eq(32'(dout), 32'(dout_held), "dout during pause");
		end
		@(posedge fr_out_clk);
		@(negedge fr_out_clk);
		check_eq(32'(pad_out), 32'(lane_of(w, 1)), "pad_out lane 1 after pause");
		check_eq(32'(pad_oe), 32'(lane_of(e, 1)), "pad_oe lane 1 after pause");
		check_eq(32'(hr_strobe), 32'(1), "hr_strobe after pause");
	endtask

	// each lane reaches the pad one cycle after its slot edge, so the captured
	// word holds lane 1 of the older word and lane 0 of the newer one
	task automatic loopback;
		logic [WORD_BITS-1:0] w [NUM_WORDS];
		for (int j = 0; j < NUM_WORDS; j++) begin
			w[j] = WORD_BITS'($urandom);
		end
		wait_word_end_edge();
		for (int j = 0; j <= NUM_WORDS; j++) begin
			if (j < NUM_WORDS) begin
				din <= w[j];
				oe <= '1;
			end
			@(negedge fr_out_clk);
			if (j >= 2) begin
				check_eq(32'(dout_valid), 32'(1), "dout_valid in loopback");
				check_eq(32'(dout), 32'(pack_lanes(lane_of(w[j-2], 1), lane_of(w[j-1], 0))),
					"dout in loopback");
			end
			if (j < NUM_WORDS) begin
				repeat (GEAR_RATIO) @(posedge fr_out_clk);
			end
		end
	endtask

	task automatic sync_clear;
		wait_word_end_edge();
		din <= WORD_BITS'($urandom);
		oe <= '1;
		ext_in <= PIN_COUNT'($urandom);
		@(posedge fr_out_clk);
		sclr <= 1'b1;
		@(negedge fr_out_clk);
		check_eq(32'(hr_strobe), 32'(0), "hr_strobe before clear");
		@(posedge fr_out_clk);
		sclr <= 1'b0;
		@(negedge fr_out_clk);
		check_eq(32'(pad_out), 32'(0), "pad_out after sclr");
		check_eq(32'(pad_oe), 32'(0), "pad_oe after sclr");
		check_eq(32'(dout), 32'(0), "dout after sclr");
		check_eq(32'(dout_valid), 32'(0), "dout_valid after sclr");
		check_eq(32'(hr_strobe), 32'(1), "hr_strobe keeps counting through sclr");
		@(posedge fr_out_clk);
		@(negedge fr_out_clk);
		check_eq(32'(hr_strobe), 32'(0), "hr_strobe one cycle after sclr");
	endtask

	initial begin
		fr_out_clk = 1'b0;
		rst_n = 1'b0;
		cke = 1'b1;
		sclr = 1'b0;
		din = '0;
		oe = '0;
		ext_in = '0;
		void'($urandom(SEED));
		reset_dut();
		verify_reset_state();
		output_gearing();
		input_gearing();
		cke_hold();
		loopback();
		sync_clear();
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge fr_out_clk);
		$display("ERROR: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule : gpio_tb

`default_nettype wire

//--- verilog.f
hdl/gpio_cfg_pkg.sv
hdl/gpio_lane_pkg.sv
hdl/gear_phase_ctr.sv
hdl/gear_serializer.sv
hdl/gear_deserializer.sv
hdl/gpio_top.sv
bench/gpio_props.sv
bench/gpio_tb.sv

//--- run.sh
#!/bin/sh
# Build the gpio testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the run ends in $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module gpio_tb -f verilog.f -o gpio_sim \
	&& ./obj_dir/gpio_sim \
	|| { echo "simulation run did not complete successfully"; exit 1; }

exit 0
